//--- Makefile
VERILATOR ?= verilator
TOP ?= cameraTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- burstWriter.sv
`timescale 1ns/1ps
`default_nettype none

module burstWriter
  (input  logic                     clock,
   input  logic                     reset,
   input  logic                     lineDone,
   input  logic                     frameStart,
   input  logic                     captureEnable,
   input  cameraPkg::busWord_t      frameBase,
   input  cameraPkg::byteCount_t    bytesPerLine,
   output cameraPkg::wordAddress_t  readAddress,
   input  cameraPkg::busWord_t      readData,
   output cameraPkg::busMasterOut_t busOut,
   input  cameraPkg::busMasterIn_t  busIn);

  cameraPkg::writerState_t state;
  cameraPkg::writerState_t nextState;
  cameraPkg::wordAddress_t wordsLeft;
  cameraPkg::wordAddress_t burstLeft;
  cameraPkg::wordAddress_t burstWords;
  cameraPkg::wordAddress_t readAddressReg;
  cameraPkg::busWord_t memoryAddress;
  cameraPkg::busWord_t dataReg;
  cameraPkg::burstSize_t sizeReg;
  logic [3:0] enablesReg;
  logic beginReg;
  logic endReg;
  logic validReg;
  logic startLine;
  logic grantNow;
  logic doWrite;
  logic abortNow;
  logic closeBurst;

  assign startLine = (state == cameraPkg::idle) & lineDone & captureEnable;
  assign grantNow  = (state == cameraPkg::requestBus) & busIn.busGrant;
  // a word moves only while the slave is ready and no error is flagged
  assign doWrite   = (state == cameraPkg::doBurst) & (burstLeft != '0) &
                     ~busIn.busy & ~busIn.busError;
  assign abortNow  = (state == cameraPkg::doBurst) & busIn.busError;
  // the last word has been accepted once busy is low with nothing left
  assign closeBurst = abortNow |
                      ((state == cameraPkg::doBurst) & (burstLeft == '0) & ~busIn.busy);

  assign burstWords = (wordsLeft > cameraPkg::maxBurstWords) ?
                      cameraPkg::wordAddress_t'(cameraPkg::maxBurstWords) : wordsLeft;

  always_comb
  begin
    nextState = state;
    case (state)
      cameraPkg::idle:
        if (startLine && bytesPerLine[10:2] != '0)
          nextState = cameraPkg::requestBus;
      cameraPkg::requestBus:
        if (busIn.busGrant)
          nextState = cameraPkg::initBurst;
      cameraPkg::initBurst:
        nextState = cameraPkg::doBurst;
      cameraPkg::doBurst:
        if (abortNow)
          nextState = cameraPkg::abortBurst;
        else if (closeBurst)
          nextState = cameraPkg::endBurst;
      cameraPkg::endBurst:
        nextState = (wordsLeft != '0) ? cameraPkg::requestBus : cameraPkg::idle;
      default:
        nextState = cameraPkg::idle;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state          <= cameraPkg::idle;
      wordsLeft      <= '0;
      burstLeft      <= '0;
      readAddressReg <= '0;
      beginReg       <= 1'b0;
      endReg         <= 1'b0;
      validReg       <= 1'b0;
      enablesReg     <= 4'h0;
      sizeReg        <= '0;
      dataReg        <= '0;
    end
    else
    begin
      state    <= nextState;
      // header fields are set up at the grant and shown for one cycle
      beginReg   <= grantNow;
      enablesReg <= grantNow ? 4'hF : 4'h0;
      sizeReg    <= grantNow ? cameraPkg::burstSize_t'(burstWords - 1'b1) : '0;
      endReg     <= closeBurst;

      if (grantNow)
        dataReg <= memoryAddress;
      else if (doWrite)
        dataReg <= readData;
      else if (!busIn.busy || abortNow)
        dataReg <= '0;

      if (doWrite)
        validReg <= 1'b1;
      else if (!busIn.busy || abortNow)
        validReg <= 1'b0;

      if (startLine)
      begin
        wordsLeft      <= bytesPerLine[10:2];
        readAddressReg <= '0;
      end
      else if (grantNow)
      begin
        wordsLeft <= wordsLeft - burstWords;
        burstLeft <= burstWords;
      end
      else if (abortNow)
      begin
        // whatever remains of this line is dropped
        wordsLeft <= '0;
        burstLeft <= '0;
      end
      else if (doWrite)
      begin
        burstLeft      <= burstLeft - 1'b1;
        readAddressReg <= readAddressReg + 1'b1;
      end
    end
  end

  // running memory address, so an aborted line leaves the next one right behind it
  always_ff @(posedge clock)
  begin
    if (reset || frameStart)
      memoryAddress <= frameBase;
    else if (doWrite)
      memoryAddress <= memoryAddress + 32'd4;
  end

  assign readAddress = readAddressReg;

  always_comb
  begin
    busOut.requestBus       = (state == cameraPkg::requestBus);
    busOut.beginTransaction = beginReg;
    busOut.endTransaction   = endReg;
    busOut.dataValid        = validReg;
    busOut.byteEnables      = enablesReg;
    busOut.burstSize        = sizeReg;
    busOut.addressData      = dataReg;
  end

endmodule

`default_nettype wire

//--- camera.sv
`timescale 1ns/1ps
`default_nettype none

module camera
  (input  logic                     clock,
   input  logic                     reset,
   input  logic                     hsync,
   input  logic                     vsync,
   input  logic [7:0]               camData,
   input  cameraPkg::ciRequest_t    ciRequest,
   output cameraPkg::ciResponse_t   ciResponse,
   output cameraPkg::busMasterOut_t busOut,
   input  cameraPkg::busMasterIn_t  busIn);

  logic bufferWrite;
  cameraPkg::wordAddress_t bufferAddress;
  cameraPkg::busWord_t bufferData;
  cameraPkg::captureStatus_t status;
  logic lineDone;
  logic frameStart;
  cameraPkg::busWord_t frameBase;
  logic captureEnable;
  cameraPkg::wordAddress_t readAddress;
  cameraPkg::busWord_t readData;

  lineCapture capture_i
    (.clock         (clock),
     .reset         (reset),
     .hsync         (hsync),
     .vsync         (vsync),
     .camData       (camData),
     .bufferWrite   (bufferWrite),
     .bufferAddress (bufferAddress),
     .bufferData    (bufferData),
     .status        (status),
     .lineDone      (lineDone),
     .frameStart    (frameStart));

  lineBuffer buffer_i
    (.clock        (clock),
     .writeEnable  (bufferWrite),
     .writeAddress (bufferAddress),
     .writeData    (bufferData),
     .readAddress  (readAddress),
     .readData     (readData));

  ciRegisters registers_i
    (.clock         (clock),
     .reset         (reset),
     .request       (ciRequest),
     .response      (ciResponse),
     .status        (status),
     .frameStart    (frameStart),
     .frameBase     (frameBase),
     .captureEnable (captureEnable));

  burstWriter writer_i
    (.clock         (clock),
     .reset         (reset),
     .lineDone      (lineDone),
     .frameStart    (frameStart),
     .captureEnable (captureEnable),
     .frameBase     (frameBase),
     .bytesPerLine  (status.bytesPerLine),
     .readAddress   (readAddress),
     .readData      (readData),
     .busOut        (busOut),
     .busIn         (busIn));

endmodule

`default_nettype wire

//--- cameraPkg.sv
`default_nettype none

package cameraPkg;

  // plain vector types
  typedef logic [31:0] busWord_t;
  typedef logic [10:0] byteCount_t;
  typedef logic [10:0] lineCount_t;
  typedef logic [8:0]  wordAddress_t;
  typedef logic [7:0]  burstSize_t;

  localparam logic [7:0] ciInstructionId = 8'd0;
  localparam int maxBurstWords = 16;
  localparam int lineBufferWords = 512;

  // custom-instruction command codes, taken from valueA bits 3..0
  localparam logic [3:0] cmdBytesPerLine   = 4'd0;
  localparam logic [3:0] cmdLinesPerFrame  = 4'd1;
  localparam logic [3:0] cmdReadFrameBase  = 4'd4;
  localparam logic [3:0] cmdWriteFrameBase = 4'd5;
  localparam logic [3:0] cmdControl        = 4'd6;
  localparam logic [3:0] cmdSingleDone     = 4'd7;

  // values of valueB bits 1..0 for cmdControl
  localparam logic [1:0] ctrlStop       = 2'd0;
  localparam logic [1:0] ctrlContinuous = 2'd1;
  localparam logic [1:0] ctrlSingle     = 2'd2;

  typedef enum logic [2:0] {
    idle,
    requestBus,
    initBurst,
    doBurst,
    endBurst,
    abortBurst
  } writerState_t;

  typedef struct packed {
    logic       start;
    logic       cke;
    logic [7:0] n;
    busWord_t   valueA;
    busWord_t   valueB;
  } ciRequest_t;

  typedef struct packed {
    logic     done;
    busWord_t result;
  } ciResponse_t;

  typedef struct packed {
    byteCount_t bytesPerLine;
    lineCount_t linesPerFrame;
  } captureStatus_t;

  typedef struct packed {
    logic       requestBus;
    logic       beginTransaction;
    logic       endTransaction;
    logic       dataValid;
    logic [3:0] byteEnables;
    burstSize_t burstSize;
    busWord_t   addressData;
  } busMasterOut_t;

  typedef struct packed {
    logic busGrant;
    logic busy;
    logic busError;
  } busMasterIn_t;

endpackage

`default_nettype wire

//--- cameraTb.sv
`timescale 1ns/1ps
`default_nettype none

module cameraTb;

  logic clock;
  logic reset;
  logic hsync;
  logic vsync;
  logic [7:0] camData;
  cameraPkg::ciRequest_t ciRequest;
  cameraPkg::ciResponse_t ciResponse;
  cameraPkg::busMasterOut_t busOut;
  cameraPkg::busMasterIn_t busIn;

  integer seed;
  cameraPkg::busWord_t expWords[$];
  cameraPkg::busWord_t wordAddr[$];
  cameraPkg::busWord_t wordData[$];
  cameraPkg::busWord_t hdrAddr[$];
  int hdrSize[$];
  logic [3:0] hdrEnables[$];
  int burstCounts[$];
  cameraPkg::busWord_t curAddr;
  int curCount;
  int grantDelay;
  logic injectError;
  int headerIndex;
  cameraPkg::busWord_t base;

  clockGen clockGen_i
    (.clock (clock),
     .reset (reset));

  camera dut_i
    (.clock      (clock),
     .reset      (reset),
     .hsync      (hsync),
     .vsync      (vsync),
     .camData    (camData),
     .ciRequest  (ciRequest),
     .ciResponse (ciResponse),
     .busOut     (busOut),
     .busIn      (busIn));

  // the bus slave grants after a random delay, raises busy at random and records every word
  always @(posedge clock)
  begin
    if (reset)
    begin
      busIn      <= '0;
      grantDelay <= 0;
    end
    else
    begin
      busIn.busGrant <= 1'b0;
      if (busOut.requestBus && !busIn.busGrant)
      begin
        if (grantDelay == 0)
        begin
          busIn.busGrant <= 1'b1;
          grantDelay     <= $random(seed) & 3;
        end
        else
          grantDelay <= grantDelay - 1;
      end
      busIn.busy     <= ($random(seed) & 3) == 0;
      busIn.busError <= 1'b0;
      if (busOut.beginTransaction)
      begin
        hdrAddr.push_back(busOut.addressData);
        hdrSize.push_back(int'(busOut.burstSize));
        hdrEnables.push_back(busOut.byteEnables);
        curAddr  = busOut.addressData;
        curCount = 0;
        // the error lands on the first data cycle before any word of this burst
        if (injectError && headerIndex == 1)
        begin
          busIn.busError <= 1'b1;
          injectError    <= 1'b0;
        end
        headerIndex <= headerIndex + 1;
      end
      if (busOut.dataValid && !busIn.busy)
      begin
        wordAddr.push_back(curAddr + 32'(4 * curCount));
        wordData.push_back(busOut.addressData);
        curCount = curCount + 1;
      end
      if (busOut.endTransaction)
        burstCounts.push_back(curCount);
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("timed out while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic ciAccess(input logic [7:0] n, input logic [3:0] index,
                          input cameraPkg::busWord_t valueB,
                          output cameraPkg::busWord_t result, output logic done);
    @(posedge clock);
    ciRequest <= '{start: 1'b1, cke: 1'b1, n: n, valueA: {28'd0, index}, valueB: valueB};
    @(negedge clock);
    done   = ciResponse.done;
    result = ciResponse.result;
    @(posedge clock);
    ciRequest <= '0;
  endtask

  task automatic readReg(input logic [3:0] index, input cameraPkg::busWord_t expected,
                         input string what);
    cameraPkg::busWord_t result;
    logic done;
    ciAccess(cameraPkg::ciInstructionId, index, 32'd0, result, done);
    checkValue(done, 1'b1, {what, " done"});
    checkValue(result, expected, what);
  endtask

  task automatic writeReg(input logic [3:0] index, input cameraPkg::busWord_t value);
    cameraPkg::busWord_t result;
    logic done;
    ciAccess(cameraPkg::ciInstructionId, index, value, result, done);
    checkValue(done, 1'b1, "write done");
  endtask

  task automatic frameStartPulse;
    @(posedge clock);
    vsync <= 1'b1;
    repeat (3) @(posedge clock);
    vsync <= 1'b0;
    repeat (5) @(posedge clock);
  endtask

  task automatic sendLine(input int bytes);
    logic [7:0] b [4];
    for (int i = 0; i < bytes; i++)
    begin
      @(posedge clock);
      b[i % 4] = 8'($random(seed));
      hsync   <= 1'b1;
      camData <= b[i % 4];
      // two pixels per word with the first byte of each pixel as its high byte
      if (i % 4 == 3)
        expWords.push_back({b[2], b[3], b[0], b[1]});
    end
    @(posedge clock);
    hsync   <= 1'b0;
    camData <= 8'd0;
  endtask

  task automatic clearRecords;
    expWords.delete();
    wordAddr.delete();
    wordData.delete();
    hdrAddr.delete();
    hdrSize.delete();
    hdrEnables.delete();
    burstCounts.delete();
  endtask

  task automatic waitBus(input int words);
    int count;
    count = 0;
    while ((wordData.size() < words || burstCounts.size() != hdrAddr.size()) && count < 3000)
    begin
      @(negedge clock);
      count++;
    end
    if (wordData.size() < words || burstCounts.size() != hdrAddr.size())
      timeoutFail("line to be written to memory");
    repeat (4) @(negedge clock);
  endtask

  task automatic checkLines(input cameraPkg::busWord_t startAddr);
    checkValue(wordData.size(), expWords.size(), "word count");
    for (int i = 0; i < expWords.size(); i++)
    begin
      checkValue(wordAddr[i], startAddr + 32'(4 * i), "word address");
      checkValue(wordData[i], expWords[i], "word data");
    end
    for (int i = 0; i < hdrAddr.size(); i++)
    begin
      checkValue(hdrEnables[i], 4'hF, "byteEnables in the header");
      checkValue(hdrSize[i] + 1, burstCounts[i], "burst length against burstSize");
      checkValue(burstCounts[i] <= cameraPkg::maxBurstWords, 1'b1, "burst too long");
    end
  endtask

  task automatic resetDefaults;
    cameraPkg::busWord_t result;
    logic done;
    int count;
    count = 0;
    while (reset && count < 20)
    begin
      @(negedge clock);
      count++;
    end
    if (reset)
      timeoutFail("reset release");
    checkValue({busOut.requestBus, busOut.beginTransaction, busOut.endTransaction,
                busOut.dataValid}, 4'd0, "bus flags after reset");
    checkValue(busOut.byteEnables, 4'd0, "byteEnables after reset");
    checkValue(busOut.burstSize, 8'd0, "burstSize after reset");
    checkValue(busOut.addressData, 32'd0, "addressData after reset");
    ciAccess(8'd3, cameraPkg::cmdReadFrameBase, 32'd0, result, done);
    checkValue(done, 1'b0, "done for another instruction");
    checkValue(result, 32'd0, "result for another instruction");
    readReg(cameraPkg::cmdReadFrameBase, 32'd0, "frame base after reset");
  endtask

  task automatic frameBaseAccess;
    writeReg(cameraPkg::cmdWriteFrameBase, 32'h1234_5677);
    readReg(cameraPkg::cmdReadFrameBase, 32'h1234_5674, "frame base low bits");
    readReg(4'd2, 32'd0, "unknown index 2");
    readReg(4'd3, 32'd0, "unknown index 3");
    readReg(4'd8, 32'd0, "unknown index 8");
    readReg(4'd15, 32'd0, "unknown index 15");
  endtask

  task automatic continuousGrab;
    writeReg(cameraPkg::cmdWriteFrameBase, base);
    writeReg(cameraPkg::cmdControl, 32'(cameraPkg::ctrlContinuous));
    frameStartPulse();
    clearRecords();
    for (int l = 0; l < 3; l++)
    begin
      sendLine(160);
      waitBus(expWords.size());
    end
    checkLines(base);
    frameStartPulse();
    readReg(cameraPkg::cmdBytesPerLine, 32'd160, "bytes per line");
    readReg(cameraPkg::cmdLinesPerFrame, 32'd3, "lines per frame");
    // a new frame starts again at the frame base
    clearRecords();
    sendLine(64);
    waitBus(expWords.size());
    checkLines(base);
  endtask

  task automatic singleFrameGrab;
    writeReg(cameraPkg::cmdControl, 32'(cameraPkg::ctrlStop));
    frameStartPulse();
    clearRecords();
    sendLine(32);
    repeat (40) @(negedge clock);
    checkValue(wordData.size(), 0, "words while stopped");
    writeReg(cameraPkg::cmdControl, 32'(cameraPkg::ctrlSingle));
    frameStartPulse();
    clearRecords();
    sendLine(96);
    waitBus(expWords.size());
    sendLine(96);
    waitBus(expWords.size());
    checkLines(base);
    frameStartPulse();
    clearRecords();
    sendLine(32);
    repeat (40) @(negedge clock);
    checkValue(wordData.size(), 0, "words after the single frame");
    readReg(cameraPkg::cmdSingleDone, 32'd1, "single done set");
    readReg(cameraPkg::cmdSingleDone, 32'd0, "single done cleared");
  endtask

  task automatic busErrorAbort;
    int count;
    writeReg(cameraPkg::cmdControl, 32'(cameraPkg::ctrlContinuous));
    frameStartPulse();
    clearRecords();
    @(negedge clock);
    headerIndex = 0;
    injectError = 1'b1;
    sendLine(160);
    count = 0;
    while (burstCounts.size() < 2 && count < 2000)
    begin
      @(negedge clock);
      count++;
    end
    if (burstCounts.size() < 2)
      timeoutFail("the aborted burst to end");
    repeat (30) @(negedge clock);
    checkValue(hdrAddr.size(), 2, "bursts of the aborted line");
    checkValue(burstCounts[1], 0, "words in the aborted burst");
    checkValue(wordData.size(), 16, "words of the aborted line");
    for (int i = 0; i < 16; i++)
      checkValue(wordData[i], expWords[i], "data before abort");
    clearRecords();
    sendLine(160);
    waitBus(expWords.size());
    checkLines(base + 32'd64);
  endtask

  initial
  begin
    seed        = 32'hdfe7_aa73;
    hsync       = 1'b0;
    vsync       = 1'b0;
    camData     = 8'd0;
    ciRequest   = '0;
    busIn       = '0;
    injectError = 1'b0;
    headerIndex = 0;
    base        = 32'h2000_0000;
    resetDefaults();
    frameBaseAccess();
    continuousGrab();
    singleFrameGrab();
    busErrorAbort();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- cameraTb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cameraTb_asserts
  (input logic                     clock,
   input logic                     reset,
   input cameraPkg::busMasterOut_t busOut,
   input cameraPkg::busMasterIn_t  busIn);

  // the burst header is a single cycle
  headerOneCycle: assert property (@(posedge clock) disable iff (reset)
    busOut.beginTransaction |=> !busOut.beginTransaction)
    else $error("beginTransaction lasted more than one cycle");

  // a header only ever follows a grant
  headerAfterGrant: assert property (@(posedge clock) disable iff (reset)
    $rose(busOut.beginTransaction) |-> $past(busIn.busGrant))
    else $error("beginTransaction without a preceding busGrant");

  // a new word is launched only from a cycle where the slave was ready
  validNotWhileBusy: assert property (@(posedge clock) disable iff (reset)
    $rose(busOut.dataValid) |-> !$past(busIn.busy))
    else $error("dataValid rose while the slave was busy");

  burstSizeLimit: assert property (@(posedge clock) disable iff (reset)
    busOut.burstSize < cameraPkg::maxBurstWords)
    else $error("burstSize out of range");

endmodule

bind camera cameraTb_asserts asserts_i (.*);

`default_nettype wire

//--- ciRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module ciRegisters
  (input  logic                      clock,
   input  logic                      reset,
   input  cameraPkg::ciRequest_t     request,
   output cameraPkg::ciResponse_t    response,
   input  cameraPkg::captureStatus_t status,
   input  logic                      frameStart,
   output cameraPkg::busWord_t       frameBase,
   output logic                      captureEnable);

  logic isMine;
  logic [3:0] index;
  cameraPkg::busWord_t frameBaseReg;
  cameraPkg::busWord_t selected;
  logic continuousReg;
  logic singleArmedReg;
  logic singleActiveReg;
  logic singleDoneReg;
  logic captureEnableReg;

  assign isMine = request.start & request.cke & (request.n == cameraPkg::ciInstructionId);
  assign index  = request.valueA[3:0];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      frameBaseReg     <= '0;
      continuousReg    <= 1'b0;
      singleArmedReg   <= 1'b0;
      singleActiveReg  <= 1'b0;
      singleDoneReg    <= 1'b0;
      captureEnableReg <= 1'b0;
    end
    else
    begin
      // requests only take effect at a frame boundary
      if (frameStart)
      begin
        captureEnableReg <= continuousReg | singleArmedReg;
        singleActiveReg  <= singleArmedReg;
        singleArmedReg   <= 1'b0;
      end
      if (isMine && index == cameraPkg::cmdWriteFrameBase)
        frameBaseReg <= {request.valueB[31:2], 2'b00};
      if (isMine && index == cameraPkg::cmdControl)
      begin
        case (request.valueB[1:0])
          cameraPkg::ctrlStop:
          begin
            continuousReg  <= 1'b0;
            singleArmedReg <= 1'b0;
          end
          cameraPkg::ctrlContinuous:
          begin
            continuousReg  <= 1'b1;
            singleArmedReg <= 1'b0;
          end
          cameraPkg::ctrlSingle:
          begin
            continuousReg  <= 1'b0;
            singleArmedReg <= 1'b1;
          end
          default:
          begin
            continuousReg  <= 1'b0;
            singleArmedReg <= 1'b0;
          end
        endcase
      end
      // reading the done flag clears it, a new completion in the same cycle wins
      if (isMine && index == cameraPkg::cmdSingleDone)
        singleDoneReg <= 1'b0;
      if (frameStart && singleActiveReg)
        singleDoneReg <= 1'b1;
    end
  end

  always_comb
  begin
    case (index)
      cameraPkg::cmdBytesPerLine:  selected = cameraPkg::busWord_t'(status.bytesPerLine);
      cameraPkg::cmdLinesPerFrame: selected = cameraPkg::busWord_t'(status.linesPerFrame);
      cameraPkg::cmdReadFrameBase: selected = frameBaseReg;
      cameraPkg::cmdSingleDone:    selected = {31'd0, singleDoneReg};
      default:                     selected = '0;
    endcase
  end

  always_comb
  begin
    response.done   = isMine;
    response.result = isMine ? selected : '0;
  end

  assign frameBase     = frameBaseReg;
  assign captureEnable = captureEnableReg;

endmodule

`default_nettype wire

//--- clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
  (output logic clock,
   output logic reset);

  // 20 ns period, reset held through the first four rising edges
  initial
  begin
    clock = 1'b0;
    forever
      #10 clock = ~clock;
  end

  initial
  begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- lineBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module lineBuffer
  (input  logic                    clock,
   input  logic                    writeEnable,
   input  cameraPkg::wordAddress_t writeAddress,
   input  cameraPkg::busWord_t     writeData,
   input  cameraPkg::wordAddress_t readAddress,
   output cameraPkg::busWord_t     readData);

  // one sensor line, drained by the bus writer during the line gap
  cameraPkg::busWord_t memory [cameraPkg::lineBufferWords];

  always_ff @(posedge clock)
  begin
    if (writeEnable)
      memory[writeAddress] <= writeData;
  end

  // the writer needs the word in the cycle it selects the address
  assign readData = memory[readAddress];

endmodule

`default_nettype wire

//--- lineCapture.sv
`timescale 1ns/1ps
`default_nettype none

module lineCapture
  (input  logic                      clock,
   input  logic                      reset,
   input  logic                      hsync,
   input  logic                      vsync,
   input  logic [7:0]                camData,
   output logic                      bufferWrite,
   output cameraPkg::wordAddress_t   bufferAddress,
   output cameraPkg::busWord_t       bufferData,
   output cameraPkg::captureStatus_t status,
   output logic                      lineDone,
   output logic                      frameStart);

  logic [1:0] hsyncDelay;
  logic [1:0] vsyncDelay;
  logic hsyncFall;
  logic vsyncFall;
  cameraPkg::byteCount_t byteCount;
  cameraPkg::lineCount_t lineCount;
  cameraPkg::captureStatus_t statusReg;
  logic [7:0] byte0Reg;
  logic [7:0] byte1Reg;
  logic [7:0] byte2Reg;

  // the edge shows up one cycle after the first low sample
  assign hsyncFall = hsyncDelay[1] & ~hsyncDelay[0];
  assign vsyncFall = vsyncDelay[1] & ~vsyncDelay[0];

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      hsyncDelay <= 2'b00;
      vsyncDelay <= 2'b00;
      byteCount  <= '0;
      lineCount  <= '0;
      statusReg  <= '0;
      lineDone   <= 1'b0;
      frameStart <= 1'b0;
    end
    else
    begin
      hsyncDelay <= {hsyncDelay[0], hsync};
      vsyncDelay <= {vsyncDelay[0], vsync};
      lineDone   <= hsyncFall;
      frameStart <= vsyncFall;
      if (hsyncFall)
      begin
        byteCount              <= '0;
        statusReg.bytesPerLine <= byteCount;
      end
      else if (hsync)
        byteCount <= byteCount + 1'b1;
      // lines are counted at the end of each line and latched at the next frame start
      if (vsyncFall)
      begin
        lineCount               <= '0;
        statusReg.linesPerFrame <= lineCount;
      end
      else if (hsyncFall)
        lineCount <= lineCount + 1'b1;
    end
  end

  // the first three bytes of a group wait here for the fourth
  always_ff @(posedge clock)
  begin
    if (hsync && byteCount[1:0] == 2'd0)
      byte0Reg <= camData;
    if (hsync && byteCount[1:0] == 2'd1)
      byte1Reg <= camData;
    if (hsync && byteCount[1:0] == 2'd2)
      byte2Reg <= camData;
  end

  assign bufferWrite   = hsync & (byteCount[1:0] == 2'd3);
  assign bufferAddress = byteCount[10:2];
  // second pixel goes to the upper half, each pixel has its first byte on top
  assign bufferData    = {byte2Reg, camData, byte0Reg, byte1Reg};
  assign status        = statusReg;

endmodule

`default_nettype wire

//--- list.f
cameraPkg.sv
lineCapture.sv
lineBuffer.sv
ciRegisters.sv
burstWriter.sv
camera.sv
clockGen.sv
cameraTb_asserts.sv
cameraTb.sv
